/* list.f */
+incdir+src
src/trace_pkg.sv
src/trace_beat_if.sv
src/trace_header_gen.sv
src/trace_encoder.sv
src/trace_writer.sv
src/trace_top.sv
test/trace_clock.sv
test/trace_properties.sv
test/trace_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module trace_tb -o trace_sim &&
./obj_dir/trace_sim +verilator+error+limit+100 | tee /dev/stderr | \
    grep -qx "Regression passed" || exit 1

/* test/trace_tb.sv */
`timescale 1ns/1ps
`include "trace_params.svh"
`default_nettype none

module trace_tb;

    typedef struct {
        string       name;
        logic [4:0]  mask;     // Bit 0 is AR, bit 4 is B.
        logic [31:0] pl [5];
        logic        second;
        logic        en;
        logic [7:0]  stall;    // Rotating mem_ready pattern.
    } row_t;

    localparam int NROWS = 14;

    logic                     clk;
    logic                     rst;
    logic                     trace_en;
    logic                     mem_ready;
    logic [4:0]               chan_valid;
    logic [4:0]               chan_ready;
    logic [31:0]              payload [5];
    logic                     mem_wr_en;
    logic [`TRACE_ADDR_W-1:0] mem_addr;
    logic [`TRACE_BEAT_W-1:0] mem_wr_data;
    logic [15:0]              record_count;
    logic [15:0]              drop_count;

    row_t        tests [NROWS];
    logic [63:0] mem [0:65535];
    int          wr_total = 0;
    int          edge_cnt = 0;
    int          errors = 0;
    int          wr_ptr = 0;
    logic [15:0] seq_next = '0;
    logic [47:0] prev_ts = '0;
    bit          have_prev = 0;
    bit          timed_out = 0;
    logic [7:0]  stall_pat = 8'hFF;
    integer      seed;

    trace_clock u_clock (.clk(clk));

    trace_top UUT (
        .clk          (clk),
        .rst          (rst),
        .trace_en     (trace_en),
        .ar_valid     (chan_valid[0]),
        .ar_ready     (chan_ready[0]),
        .ar_payload   (payload[0]),
        .aw_valid     (chan_valid[1]),
        .aw_ready     (chan_ready[1]),
        .aw_payload   (payload[1]),
        .w_valid      (chan_valid[2]),
        .w_ready      (chan_ready[2]),
        .w_payload    (payload[2]),
        .r_valid      (chan_valid[3]),
        .r_ready      (chan_ready[3]),
        .r_payload    (payload[3]),
        .b_valid      (chan_valid[4]),
        .b_ready      (chan_ready[4]),
        .b_payload    (payload[4]),
        .mem_wr_en    (mem_wr_en),
        .mem_addr     (mem_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_ready    (mem_ready),
        .record_count (record_count),
        .drop_count   (drop_count)
    );

    // Memory model.
    always @(posedge clk) begin
        if (mem_wr_en && mem_ready) begin
            mem[mem_addr] <= mem_wr_data;
            wr_total <= wr_total + 1;
        end
    end

    task automatic set_row(input int i, input string name, input logic [4:0] mask,
                           input logic second, input logic en, input logic stall);
        int c;
        tests[i].name = name;
        tests[i].mask = mask;
        tests[i].second = second;
        tests[i].en = en;
        for (c = 0; c < 5; c++) begin
            tests[i].pl[c] = {8'hA5, 8'(i), 8'(c), 8'h3C};
        end
        tests[i].stall = stall ? (8'($random(seed)) | 8'h01) : 8'hFF;
    endtask

    task automatic load_tests();
        set_row(0, "ar_only", 5'b00001, 1'b0, 1'b1, 1'b0);
        set_row(1, "aw_only", 5'b00010, 1'b0, 1'b1, 1'b0);
        set_row(2, "w_only", 5'b00100, 1'b0, 1'b1, 1'b0);
        set_row(3, "r_only", 5'b01000, 1'b0, 1'b1, 1'b0);
        set_row(4, "b_only", 5'b10000, 1'b0, 1'b1, 1'b0);
        set_row(5, "ar_w_b", 5'b10101, 1'b0, 1'b1, 1'b0);
        set_row(6, "all_channels", 5'b11111, 1'b0, 1'b1, 1'b0);
        set_row(7, "drop_while_busy", 5'b00110, 1'b1, 1'b1, 1'b0);
        set_row(8, "stall_a", 5'b01001, 1'b0, 1'b1, 1'b1);
        set_row(9, "stall_b", 5'b10010, 1'b0, 1'b1, 1'b1);
        set_row(10, "trace_disabled", 5'b00011, 1'b0, 1'b0, 1'b0);
        set_row(11, "wrap_a", 5'b01100, 1'b0, 1'b1, 1'b0);
        set_row(12, "wrap_b", 5'b10001, 1'b1, 1'b1, 1'b1);
        set_row(13, "wrap_c", 5'b00111, 1'b0, 1'b1, 1'b0);
    endtask

    function automatic logic [255:0] build_record(input row_t t, input logic [15:0] seq,
                                                  input logic [47:0] ts);
        logic [31:0] slot [5];
        int c;
        for (c = 0; c < 5; c++) begin
            slot[c] = t.mask[c] ? t.pl[c] : 32'h0;   // Silent channels are zeroed.
        end
        return {24'h0, seq, ts, 3'b000, t.mask, slot[0], slot[1], slot[2], slot[3], slot[4]};
    endfunction

    task automatic tick();
        @(posedge clk);
        edge_cnt++;
        mem_ready <= stall_pat[edge_cnt % 8];
    endtask

    task automatic drive_event(input row_t t, input logic on);
        int c;
        trace_en <= t.en;
        chan_valid <= on ? 5'b11111 : 5'b00000;
        chan_ready <= on ? t.mask : 5'b00000;   // Only masked channels complete.
        for (c = 0; c < 5; c++) begin
            payload[c] <= t.pl[c];
        end
    endtask

    task automatic run_row(input int i);
        row_t         t;
        logic [255:0] exp_rec;
        logic [255:0] got_rec;
        logic [63:0]  exp_beat;
        logic [47:0]  ts_exp;
        logic [15:0]  rc0;
        logic [15:0]  dc0;
        logic [15:0]  addr;
        bit           fast;
        int           wr0;
        int           err0;
        int           n;
        int           b;
        t = tests[i];
        err0 = errors;
        rc0 = record_count;
        dc0 = drop_count;
        wr0 = wr_total;
        fast = t.en && (t.stall == 8'hFF);
        stall_pat = t.stall;
        tick();
        drive_event(t, 1'b1);
        ts_exp = 48'(edge_cnt - 4);   // Cycles since reset at the event edge.
        tick();
        drive_event(t, t.second);
        @(negedge clk);
        if (fast && mem_wr_en !== 1'b0) begin
            $display("ERR %s write timing: expected 0, actual %b", t.name, mem_wr_en);
            errors++;
        end
        tick();
        drive_event(t, 1'b0);
        @(negedge clk);
        if (fast && mem_wr_en !== 1'b1) begin
            $display("ERR %s write timing: expected 1, actual %b", t.name, mem_wr_en);
            errors++;
        end
        if (!t.en) begin
            repeat (12) tick();
            @(negedge clk);
            if (record_count !== rc0 || drop_count !== dc0 || wr_total != wr0) begin
                $display("%s: recorder wrote or counted while tracing was off", t.name);
                errors++;
            end
        end else begin
            n = 0;
            while (record_count === rc0 && n < 200) begin
                tick();
                @(negedge clk);
                n++;
            end
            if (record_count === rc0) begin
                $display("%s: timed out waiting for the record to be stored", t.name);
                errors++;
                timed_out = 1;
                return;
            end
            if (record_count !== rc0 + 16'd1) begin
                $display("ERR %s record_count: expected %0d, actual %0d",
                         t.name, rc0 + 16'd1, record_count);
                errors++;
            end
            if (drop_count !== dc0 + 16'(t.second)) begin
                $display("ERR %s drop_count: expected %0d, actual %0d",
                         t.name, dc0 + 16'(t.second), drop_count);
                errors++;
            end
            if (wr_total != wr0 + `TRACE_BEATS) begin
                $display("ERR %s writes: expected %0d, actual %0d",
                         t.name, wr0 + `TRACE_BEATS, wr_total);
                errors++;
            end
            exp_rec = build_record(t, seq_next, ts_exp);
            for (b = 0; b < `TRACE_BEATS; b++) begin
                addr = `TRACE_BUF_BASE + 16'((wr_ptr + b) % `TRACE_BUF_WORDS);
                exp_beat = exp_rec[255 - 64 * b -: 64];
                got_rec[255 - 64 * b -: 64] = mem[addr];
                if (mem[addr] !== exp_beat) begin
                    $display("ERR %s beat %0d: expected %h, actual %h",
                             t.name, b + 1, exp_beat, mem[addr]);
                    errors++;
                end
            end
            if (have_prev && got_rec[215:168] <= prev_ts) begin
                $display("ERR %s timestamp: expected above %0d, actual %0d",
                         t.name, prev_ts, got_rec[215:168]);
                errors++;
            end
            prev_ts = got_rec[215:168];
            have_prev = 1;
            seq_next = seq_next + 16'd1;
            wr_ptr = (wr_ptr + `TRACE_BEATS) % `TRACE_BUF_WORDS;   // Ring wraps here.
        end
        $display("%s: %s", t.name, (errors == err0) ? "ok" : "FAILED");
    endtask

    initial begin
        int i;
        seed = 32'h1790_783c;
        rst = 1'b1;
        trace_en = 1'b0;
        mem_ready = 1'b1;
        chan_valid = 5'b00000;
        chan_ready = 5'b00000;
        for (i = 0; i < 5; i++) begin
            payload[i] = 32'h0;
        end
        load_tests();
        repeat (4) tick();
        rst <= 1'b0;
        @(negedge clk);
        for (i = 0; i < NROWS && !timed_out; i++) begin
            run_row(i);
        end
        $display("Tests %0d, errors %0d, assertion failures %0d",
                 NROWS, errors, UUT.u_props.fail_cnt);
        if (errors == 0 && UUT.u_props.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/trace_properties.sv */
`timescale 1ns/1ps
`include "trace_params.svh"
`default_nettype none

module trace_properties (
    input wire                      clk,
    input wire                      rst,
    input wire                      beat_valid,
    input wire                      beat_ready,
    input wire [`TRACE_BEAT_W-1:0]  beat_data,
    input wire                      beat_last,
    input wire                      mem_wr_en,
    input wire                      mem_ready,
    input wire [`TRACE_ADDR_W-1:0]  mem_addr,
    input wire [`TRACE_BEAT_W-1:0]  mem_wr_data
);

    int fail_cnt = 0;

    beat_stable: assert property (@(posedge clk) disable iff (rst)
        (beat_valid && !beat_ready) |=> ($stable(beat_data) && $stable(beat_last)))
        else begin
            $error("Beat data or last changed while stalled.");
            fail_cnt++;
        end

    // Pending write stays put until the memory takes it.
    wr_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_wr_en && !mem_ready) |=>
            (mem_wr_en && $stable(mem_addr) && $stable(mem_wr_data)))
        else begin
            $error("Memory write dropped or changed before mem_ready.");
            fail_cnt++;
        end

    // Each completed write moves the ring pointer one slot on.
    addr_in_ring: assert property (@(posedge clk) disable iff (rst)
        (mem_wr_en && mem_ready) |=>
            (mem_addr == `TRACE_BUF_BASE
                + (($past(mem_addr) - `TRACE_BUF_BASE + 1) % `TRACE_BUF_WORDS)))
        else begin
            $error("Memory address did not advance to the next ring slot.");
            fail_cnt++;
        end

endmodule

bind trace_top trace_properties u_props (
    .clk         (clk),
    .rst         (rst),
    .beat_valid  (beat_bus.valid),
    .beat_ready  (beat_bus.ready),
    .beat_data   (beat_bus.data),
    .beat_last   (beat_bus.last),
    .mem_wr_en   (mem_wr_en),
    .mem_ready   (mem_ready),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data)
);

`default_nettype wire

/* test/trace_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period.
    end

endmodule

`default_nettype wire

/* src/trace_top.sv */
`timescale 1ns/1ps
`include "trace_params.svh"
`default_nettype none

module trace_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        trace_en,
    input  wire                        ar_valid,
    input  wire                        ar_ready,
    input  wire [`TRACE_PAYLOAD_W-1:0] ar_payload,
    input  wire                        aw_valid,
    input  wire                        aw_ready,
    input  wire [`TRACE_PAYLOAD_W-1:0] aw_payload,
    input  wire                        w_valid,
    input  wire                        w_ready,
    input  wire [`TRACE_PAYLOAD_W-1:0] w_payload,
    input  wire                        r_valid,
    input  wire                        r_ready,
    input  wire [`TRACE_PAYLOAD_W-1:0] r_payload,
    input  wire                        b_valid,
    input  wire                        b_ready,
    input  wire [`TRACE_PAYLOAD_W-1:0] b_payload,
    output logic                       mem_wr_en,
    output logic [`TRACE_ADDR_W-1:0]   mem_addr,
    output logic [`TRACE_BEAT_W-1:0]   mem_wr_data,
    input  wire                        mem_ready,
    output logic [15:0]                record_count,
    output logic [15:0]                drop_count
);

    import trace_pkg::*;

    trace_header_t header;
    logic          capture;

    trace_beat_if beat_bus ();

    trace_header_gen u_header_gen (
        .clk     (clk),
        .rst     (rst),
        .capture (capture),
        .header  (header)
    );

    trace_encoder u_encoder (
        .clk        (clk),
        .rst        (rst),
        .trace_en   (trace_en),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .ar_payload (ar_payload),
        .aw_payload (aw_payload),
        .w_payload  (w_payload),
        .r_payload  (r_payload),
        .b_payload  (b_payload),
        .header     (header),
        .capture    (capture),
        .drop_count (drop_count),
        .beat_out   (beat_bus.source)
    );

    trace_writer u_writer (
        .clk          (clk),
        .rst          (rst),
        .beat_in      (beat_bus.sink),
        .mem_wr_en    (mem_wr_en),
        .mem_addr     (mem_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_ready    (mem_ready),
        .record_count (record_count)
    );

endmodule

`default_nettype wire

/* src/trace_writer.sv */
`timescale 1ns/1ps
`include "trace_params.svh"
`default_nettype none

module trace_writer (
    input  wire                      clk,
    input  wire                      rst,
    trace_beat_if.sink               beat_in,
    output logic                     mem_wr_en,
    output logic [`TRACE_ADDR_W-1:0] mem_addr,
    output logic [`TRACE_BEAT_W-1:0] mem_wr_data,
    input  wire                      mem_ready,
    output logic [15:0]              record_count
);

    import trace_pkg::*;

    localparam int OFF_W = $clog2(`TRACE_BUF_WORDS);

    wr_state_e        state;
    logic             last_q;
    logic [OFF_W-1:0] offset;
    logic             accept;
    logic             done;

    // A pending write that completes this edge frees the slot.
    assign beat_in.ready = (state == WR_IDLE) || mem_ready;
    assign accept        = beat_in.valid && beat_in.ready;
    assign done          = (state == WR_PEND) && mem_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WR_IDLE;
        end else if (accept) begin
            state <= WR_PEND;
        end else if (done) begin
            state <= WR_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_wr_data <= beat_in.data;
            last_q      <= beat_in.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            offset       <= '0;
            record_count <= '0;
        end else if (done) begin
            if (offset == OFF_W'(`TRACE_BUF_WORDS - 1)) begin
                offset <= '0;   // Wrap to the ring base.
            end else begin
                offset <= offset + 1'b1;
            end
            if (last_q) begin
                record_count <= record_count + 16'd1;
            end
        end
    end

    assign mem_wr_en = (state == WR_PEND);
    assign mem_addr  = `TRACE_BUF_BASE + `TRACE_ADDR_W'(offset);

endmodule

`default_nettype wire

/* src/trace_encoder.sv */
`timescale 1ns/1ps
`include "trace_params.svh"
`default_nettype none

module trace_encoder (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          trace_en,
    input  wire                          ar_valid,
    input  wire                          ar_ready,
    input  wire                          aw_valid,
    input  wire                          aw_ready,
    input  wire                          w_valid,
    input  wire                          w_ready,
    input  wire                          r_valid,
    input  wire                          r_ready,
    input  wire                          b_valid,
    input  wire                          b_ready,
    input  wire [`TRACE_PAYLOAD_W-1:0]   ar_payload,
    input  wire [`TRACE_PAYLOAD_W-1:0]   aw_payload,
    input  wire [`TRACE_PAYLOAD_W-1:0]   w_payload,
    input  wire [`TRACE_PAYLOAD_W-1:0]   r_payload,
    input  wire [`TRACE_PAYLOAD_W-1:0]   b_payload,
    input  wire trace_pkg::trace_header_t header,
    output logic                         capture,
    output logic [15:0]                  drop_count,
    trace_beat_if.source                 beat_out
);

    import trace_pkg::*;

    localparam int REC_W = `TRACE_BEATS * `TRACE_BEAT_W;
    localparam int PAD_W = REC_W - `TRACE_HEADER_W - 5 * `TRACE_PAYLOAD_W;
    localparam int CNT_W = $clog2(`TRACE_BEATS + 1);
    localparam int IDX_W = $clog2(`TRACE_BEATS);

    logic [4:0]                  fire;
    logic                        evt;
    logic                        busy;
    logic [CNT_W-1:0]            beat_cnt;
    logic [IDX_W-1:0]            beat_idx;
    trace_header_t               hdr_q;
    logic [`TRACE_PAYLOAD_W-1:0] ar_q;
    logic [`TRACE_PAYLOAD_W-1:0] aw_q;
    logic [`TRACE_PAYLOAD_W-1:0] w_q;
    logic [`TRACE_PAYLOAD_W-1:0] r_q;
    logic [`TRACE_PAYLOAD_W-1:0] b_q;
    logic [`TRACE_BEATS-1:0][`TRACE_BEAT_W-1:0] record;

    // Handshake per channel.
    always_comb begin
        fire = '0;
        fire[CH_AR] = ar_valid & ar_ready;
        fire[CH_AW] = aw_valid & aw_ready;
        fire[CH_W]  = w_valid & w_ready;
        fire[CH_R]  = r_valid & r_ready;
        fire[CH_B]  = b_valid & b_ready;
    end

    assign evt     = trace_en & (|fire);
    assign busy    = (beat_cnt != '0);
    assign capture = evt & ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (capture) begin
            beat_cnt <= CNT_W'(`TRACE_BEATS);
        end else if (beat_out.valid && beat_out.ready) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    // Channels that did not fire carry a zero slot.
    always_ff @(posedge clk) begin
        if (capture) begin
            hdr_q <= '{
                seq:       header.seq,
                timestamp: header.timestamp,
                pad:       3'b000,
                chan_mask: fire
            };
            ar_q <= fire[CH_AR] ? ar_payload : '0;
            aw_q <= fire[CH_AW] ? aw_payload : '0;
            w_q  <= fire[CH_W]  ? w_payload  : '0;
            r_q  <= fire[CH_R]  ? r_payload  : '0;
            b_q  <= fire[CH_B]  ? b_payload  : '0;
        end
    end

    // One drop per event cycle, however many channels fired.
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (evt && busy) begin
            drop_count <= drop_count + 16'd1;
        end
    end

    assign record = {{PAD_W{1'b0}}, hdr_q, ar_q, aw_q, w_q, r_q, b_q};

    // Counter runs 4..1, so the top word goes out first.
    assign beat_idx       = IDX_W'(beat_cnt - 1'b1);
    assign beat_out.valid = busy;
    assign beat_out.data  = record[beat_idx];
    assign beat_out.last  = (beat_cnt == CNT_W'(1));

endmodule

`default_nettype wire

/* src/trace_header_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_header_gen (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      capture,
    output trace_pkg::trace_header_t header
);

    logic [47:0] ts_cnt;
    logic [15:0] seq_cnt;

    // Free running cycle count since reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + 48'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_cnt <= '0;
        end else if (capture) begin
            seq_cnt <= seq_cnt + 16'd1;   // Next record gets the next number.
        end
    end

    // Mask is filled in by the encoder.
    assign header = '{
        seq:       seq_cnt,
        timestamp: ts_cnt,
        pad:       3'b000,
        chan_mask: 5'b00000
    };

endmodule

`default_nettype wire

/* src/trace_beat_if.sv */
`timescale 1ns/1ps
`include "trace_params.svh"
`default_nettype none

interface trace_beat_if;

    logic                     valid;
    logic                     ready;
    logic [`TRACE_BEAT_W-1:0] data;
    logic                     last;   // Final beat of a record.

    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

/* src/trace_pkg.sv */
`default_nettype none

package trace_pkg;

    // Bit positions in the channel mask.
    typedef enum logic [2:0] {
        CH_AR = 3'd0,
        CH_AW = 3'd1,
        CH_W  = 3'd2,
        CH_R  = 3'd3,
        CH_B  = 3'd4
    } trace_chan_e;

    typedef enum logic {
        WR_IDLE = 1'b0,
        WR_PEND = 1'b1   // One write waiting for mem_ready.
    } wr_state_e;

    // 72-bit record header, top field first.
    typedef struct packed {
        logic [15:0] seq;
        logic [47:0] timestamp;
        logic [2:0]  pad;
        logic [4:0]  chan_mask;
    } trace_header_t;

endpackage

`default_nettype wire

/* src/trace_params.svh */
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

`default_nettype none

// Payload slot per channel.
`define TRACE_PAYLOAD_W 32
`define TRACE_HEADER_W 72

// Record is sent as beats, most significant beat first.
`define TRACE_BEAT_W 64
`define TRACE_BEATS 4

// Ring buffer in memory word addresses.
`define TRACE_ADDR_W 16
`define TRACE_BUF_BASE 16'h0100
`define TRACE_BUF_WORDS 32

`default_nettype wire

`endif
